//--- Makefile
# Verilator build and run for the pipelined core testbench
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbPipeCore
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The log decides pass or fail
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- src/corePkg.sv
// Shared definitions for the pipelined integer core
//   Word and register index widths
//   Opcode enum (top five bits of every instruction)
//   ALU function enum for register-format instructions
//   NOP encoding carried by a stalled issue slot
package corePkg;

    // Data and instruction width
    localparam int WORD_W = 16;

    // Eight architectural registers
    localparam int REG_AW = 3;

    // Instruction formats
    //   R: op[15:11] rs[10:8] rt[7:5] rd[4:2] func[1:0]
    //   I1: op[15:11] rs[10:8] rd[7:5] imm5[4:0]  (ADDI, LD, ST)
    //   I2: op[15:11] rs[10:8] imm8[7:0]          (LBI, BEQZ, BNEZ)
    //   J: op[15:11] disp11[10:0]
    typedef enum logic [4:0] {
        OP_HALT = 5'b00000,
        OP_NOP  = 5'b00001,
        OP_J    = 5'b00100,
        OP_ADDI = 5'b01000,
        OP_BEQZ = 5'b01100,
        OP_BNEZ = 5'b01101,
        OP_ST   = 5'b10000,
        OP_LD   = 5'b10001,
        OP_LBI  = 5'b11000,
        OP_ALU  = 5'b11011
    } opcodeT;

    // Function field of OP_ALU, bits [1:0]
    typedef enum logic [1:0] {
        FN_ADD = 2'b00,
        FN_SUB = 2'b01,
        FN_AND = 2'b10,
        FN_XOR = 2'b11
    } aluFuncT;

    // Opcode NOP, remaining fields zero
    localparam logic [WORD_W-1:0] NOP_INST = {OP_NOP, 11'b0};

endpackage

//--- src/decodeStage.sv
// Issue and decode stage
//   Program counter with stall hold and redirect load
//   Eight-entry register file with writeback bypass
//   Field decode and immediate sign extension
//   Issue-to-execute pipeline register
//   Hazard detection instance
module decodeStage import corePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic [WORD_W-1:0] inst,
    input  logic              redirect,
    input  logic [WORD_W-1:0] redirectPc,
    input  logic              memValid,
    input  logic [REG_AW-1:0] memDest,
    input  logic              memWrites,
    input  logic              wbValid,
    input  logic [REG_AW-1:0] wbReg,
    input  logic [WORD_W-1:0] wbData,
    output logic [WORD_W-1:0] pc,
    output logic              stall,
    output logic              exValid,
    output opcodeT            exOp,
    output aluFuncT           exFunc,
    output logic [REG_AW-1:0] exDest,
    output logic              exWrites,
    output logic [WORD_W-1:0] exA,
    output logic [WORD_W-1:0] exB,
    output logic [WORD_W-1:0] exImm,
    output logic [WORD_W-1:0] exNextPc,
    output logic              exX2xA,
    output logic              exX2xB,
    output logic              exM2xA,
    output logic              exM2xB
);

    logic [WORD_W-1:0] regFile [2**REG_AW];
    logic [WORD_W-1:0] issueInst;
    opcodeT            issueOp;
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic [REG_AW-1:0] dest;
    logic              writes;
    logic [WORD_W-1:0] imm;
    logic [WORD_W-1:0] readA;
    logic [WORD_W-1:0] readB;
    logic              bubble;
    logic              haltIssued;
    logic              exIsLoad;
    logic              exIsControl;
    logic              x2xA;
    logic              x2xB;
    logic              m2xA;
    logic              m2xB;

    hazardDetect uHazard (
        .inst        (inst),
        .exDest      (exDest),
        .exWrites    (exWrites),
        .exIsLoad    (exIsLoad),
        .exIsControl (exIsControl),
        .memDest     (memDest),
        .memWrites   (memValid && memWrites),
        .halting     (haltIssued),
        .issueInst   (issueInst),
        .stall       (stall),
        .x2xA        (x2xA),
        .x2xB        (x2xB),
        .m2xA        (m2xA),
        .m2xB        (m2xB)
    );

    // Flags of the instruction now in execute
    assign exIsLoad    = exValid && (exOp == OP_LD);
    assign exIsControl = exValid && (exOp == OP_J || exOp == OP_BEQZ || exOp == OP_BNEZ);

    assign issueOp = opcodeT'(issueInst[15:11]);
    assign rs      = issueInst[10:8];
    assign rt      = issueInst[7:5];
    assign bubble  = stall || redirect;

    // Destination field and immediate width depend on format
    always_comb begin
        dest   = issueInst[7:5];
        writes = 1'b0;
        imm    = {{(WORD_W-5){issueInst[4]}}, issueInst[4:0]};
        case (issueOp)
            OP_ALU: begin
                dest   = issueInst[4:2];
                writes = 1'b1;
            end
            OP_ADDI, OP_LD: writes = 1'b1;
            OP_LBI: begin
                dest   = issueInst[10:8];
                writes = 1'b1;
                imm    = {{(WORD_W-8){issueInst[7]}}, issueInst[7:0]};
            end
            OP_BEQZ, OP_BNEZ: imm = {{(WORD_W-8){issueInst[7]}}, issueInst[7:0]};
            OP_J:             imm = {{(WORD_W-11){issueInst[10]}}, issueInst[10:0]};
            default: begin
                writes = 1'b0;
            end
        endcase
    end

    // Same-cycle writeback is visible to the read
    assign readA = (wbValid && wbReg == rs) ? wbData : regFile[rs];
    assign readB = (wbValid && wbReg == rt) ? wbData : regFile[rt];

    always_ff @(posedge clk) begin
        if (wbValid) begin
            regFile[wbReg] <= wbData;
        end
    end

    // Control state: pc, slot valid, sticky halt
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc         <= '0;
            exValid    <= 1'b0;
            exWrites   <= 1'b0;
            haltIssued <= 1'b0;
        end else begin
            if (redirect) begin
                pc <= redirectPc;
            end else if (!stall) begin
                pc <= pc + 1'b1;
            end
            exValid  <= !bubble;
            exWrites <= !bubble && writes;
            if (!bubble && issueOp == OP_HALT) begin
                haltIssued <= 1'b1;
            end
        end
    end

    // Payload, qualified downstream by exValid
    always_ff @(posedge clk) begin
        exOp     <= issueOp;
        exFunc   <= aluFuncT'(issueInst[1:0]);
        exDest   <= dest;
        exA      <= readA;
        exB      <= readB;
        exImm    <= imm;
        exNextPc <= pc + 1'b1;
        exX2xA   <= x2xA;
        exX2xB   <= x2xB;
        exM2xA   <= m2xA;
        exM2xB   <= m2xB;
    end

endmodule

//--- src/executeStage.sv
// Execute stage
//   Operand forwarding from memory-stage result and writeback data
//   ALU, ADDI, LBI and load/store address generation
//   Branch and jump resolution with redirect
//   Execute-to-memory pipeline register
module executeStage import corePkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic              exValid,
    input  opcodeT            exOp,
    input  aluFuncT           exFunc,
    input  logic [REG_AW-1:0] exDest,
    input  logic              exWrites,
    input  logic [WORD_W-1:0] exA,
    input  logic [WORD_W-1:0] exB,
    input  logic [WORD_W-1:0] exImm,
    input  logic [WORD_W-1:0] exNextPc,
    input  logic              exX2xA,
    input  logic              exX2xB,
    input  logic              exM2xA,
    input  logic              exM2xB,
    input  logic [WORD_W-1:0] wbData,
    output logic              redirect,
    output logic [WORD_W-1:0] redirectPc,
    output logic              memValid,
    output opcodeT            memOp,
    output logic [REG_AW-1:0] memDest,
    output logic              memWrites,
    output logic [WORD_W-1:0] memResult,
    output logic [WORD_W-1:0] memStoreData
);

    logic [WORD_W-1:0] opA;
    logic [WORD_W-1:0] opB;
    logic [WORD_W-1:0] result;
    logic              isZero;
    logic              taken;

    // EX->EX source is the previous instruction, so it takes priority
    assign opA = exX2xA ? memResult : (exM2xA ? wbData : exA);
    assign opB = exX2xB ? memResult : (exM2xB ? wbData : exB);

    always_comb begin
        result = '0;
        case (exOp)
            OP_ALU: begin
                case (exFunc)
                    FN_ADD:  result = opA + opB;
                    FN_SUB:  result = opA - opB;
                    FN_AND:  result = opA & opB;
                    FN_XOR:  result = opA ^ opB;
                    default: result = '0;
                endcase
            end
            // Register plus imm5, also the LD/ST effective address
            OP_ADDI, OP_LD, OP_ST: result = opA + exImm;
            OP_LBI:                result = exImm;
            default:               result = '0;
        endcase
    end

    // Branches test rs against zero
    assign isZero = (opA == '0);

    always_comb begin
        case (exOp)
            OP_J:    taken = 1'b1;
            OP_BEQZ: taken = isZero;
            OP_BNEZ: taken = !isZero;
            default: taken = 1'b0;
        endcase
    end

    // Every control instruction redirects; not taken falls through to next pc
    assign redirect   = exValid && (exOp == OP_J || exOp == OP_BEQZ || exOp == OP_BNEZ);
    assign redirectPc = taken ? exNextPc + exImm : exNextPc;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            memValid  <= 1'b0;
            memWrites <= 1'b0;
        end else begin
            memValid  <= exValid;
            memWrites <= exValid && exWrites;
        end
    end

    // Store data travels with the address
    always_ff @(posedge clk) begin
        memOp        <= exOp;
        memDest      <= exDest;
        memResult    <= result;
        memStoreData <= opB;
    end

endmodule

//--- src/hazardDetect.sv
// Issue-time hazard checks
//   Load-use and control stall detection
//   NOP insertion into a stalled issue slot
//   EX->EX and MEM->EX forwarding selects for operands A and B
module hazardDetect import corePkg::*; (
    input  logic [WORD_W-1:0] inst,
    input  logic [REG_AW-1:0] exDest,
    input  logic              exWrites,
    input  logic              exIsLoad,
    input  logic              exIsControl,
    input  logic [REG_AW-1:0] memDest,
    input  logic              memWrites,
    input  logic              halting,
    output logic [WORD_W-1:0] issueInst,
    output logic              stall,
    output logic              x2xA,
    output logic              x2xB,
    output logic              m2xA,
    output logic              m2xB
);

    opcodeT            op;
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    logic              readsRs;
    logic              readsRt;
    logic              exMatchA;
    logic              exMatchB;
    logic              memMatchA;
    logic              memMatchB;
    logic              loadUse;

    assign op = opcodeT'(inst[15:11]);
    assign rs = inst[10:8];
    assign rt = inst[7:5];

    // Which source fields the opcode actually reads
    always_comb begin
        readsRs = 1'b0;
        readsRt = 1'b0;
        case (op)
            OP_BEQZ, OP_BNEZ, OP_ADDI, OP_LD: begin
                readsRs = 1'b1;
            end
            // ST data register sits in the rt position
            OP_ALU, OP_ST: begin
                readsRs = 1'b1;
                readsRt = 1'b1;
            end
            // LBI, J, NOP, HALT and unknown encodings read nothing
            default: begin
                readsRs = 1'b0;
                readsRt = 1'b0;
            end
        endcase
    end

    // Source compares against the two younger writers in flight
    assign exMatchA  = readsRs && exWrites && (rs == exDest);
    assign exMatchB  = readsRt && exWrites && (rt == exDest);
    assign memMatchA = readsRs && memWrites && (rs == memDest);
    assign memMatchB = readsRt && memWrites && (rt == memDest);

    // Load data only exists after the memory stage
    assign loadUse = exIsLoad && (exMatchA || exMatchB);

    // Hold issue while a branch resolves or once HALT has gone down the pipe
    assign stall = loadUse || exIsControl || halting;

    assign issueInst = stall ? NOP_INST : inst;

    // Execute-stage writer is younger, so it wins over memory stage
    assign x2xA = exMatchA;
    assign x2xB = exMatchB;
    assign m2xA = memMatchA && !exMatchA;
    assign m2xB = memMatchB && !exMatchB;

endmodule

//--- src/pipeCore.sv
// Top level of the four-stage integer core
//   Issue/decode, execute and memory/writeback stages
//   External instruction port and writeback strobe
module pipeCore import corePkg::*; #(
    parameter int dataAddrWidth = 8
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic [WORD_W-1:0] inst,
    output logic [WORD_W-1:0] pc,
    output logic              stall,
    output logic              wbValid,
    output logic [REG_AW-1:0] wbReg,
    output logic [WORD_W-1:0] wbData,
    output logic              halted
);

    // Issue to execute
    logic              exValid;
    opcodeT            exOp;
    aluFuncT           exFunc;
    logic [REG_AW-1:0] exDest;
    logic              exWrites;
    logic [WORD_W-1:0] exA;
    logic [WORD_W-1:0] exB;
    logic [WORD_W-1:0] exImm;
    logic [WORD_W-1:0] exNextPc;
    logic              exX2xA;
    logic              exX2xB;
    logic              exM2xA;
    logic              exM2xB;

    // Execute back to issue, and on to memory
    logic              redirect;
    logic [WORD_W-1:0] redirectPc;
    logic              memValid;
    opcodeT            memOp;
    logic [REG_AW-1:0] memDest;
    logic              memWrites;
    logic [WORD_W-1:0] memResult;
    logic [WORD_W-1:0] memStoreData;

    decodeStage uDecode (
        .clk        (clk),
        .rstN       (rstN),
        .inst       (inst),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .memValid   (memValid),
        .memDest    (memDest),
        .memWrites  (memWrites),
        .wbValid    (wbValid),
        .wbReg      (wbReg),
        .wbData     (wbData),
        .pc         (pc),
        .stall      (stall),
        .exValid    (exValid),
        .exOp       (exOp),
        .exFunc     (exFunc),
        .exDest     (exDest),
        .exWrites   (exWrites),
        .exA        (exA),
        .exB        (exB),
        .exImm      (exImm),
        .exNextPc   (exNextPc),
        .exX2xA     (exX2xA),
        .exX2xB     (exX2xB),
        .exM2xA     (exM2xA),
        .exM2xB     (exM2xB)
    );

    executeStage uExecute (
        .clk          (clk),
        .rstN         (rstN),
        .exValid      (exValid),
        .exOp         (exOp),
        .exFunc       (exFunc),
        .exDest       (exDest),
        .exWrites     (exWrites),
        .exA          (exA),
        .exB          (exB),
        .exImm        (exImm),
        .exNextPc     (exNextPc),
        .exX2xA       (exX2xA),
        .exX2xB       (exX2xB),
        .exM2xA       (exM2xA),
        .exM2xB       (exM2xB),
        .wbData       (wbData),
        .redirect     (redirect),
        .redirectPc   (redirectPc),
        .memValid     (memValid),
        .memOp        (memOp),
        .memDest      (memDest),
        .memWrites    (memWrites),
        .memResult    (memResult),
        .memStoreData (memStoreData)
    );

    resultStage #(
        .dataAddrWidth (dataAddrWidth)
    ) uResult (
        .clk          (clk),
        .rstN         (rstN),
        .memValid     (memValid),
        .memOp        (memOp),
        .memDest      (memDest),
        .memWrites    (memWrites),
        .memResult    (memResult),
        .memStoreData (memStoreData),
        .wbValid      (wbValid),
        .wbReg        (wbReg),
        .wbData       (wbData),
        .halted       (halted)
    );

endmodule

//--- src/resultStage.sv
// Memory and writeback stage
//   Word-addressed data memory
//   Synchronous load read into the writeback register
//   Writeback strobe, register and data
//   Sticky halt flag
module resultStage import corePkg::*; #(
    parameter int dataAddrWidth = 8
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              memValid,
    input  opcodeT            memOp,
    input  logic [REG_AW-1:0] memDest,
    input  logic              memWrites,
    input  logic [WORD_W-1:0] memResult,
    input  logic [WORD_W-1:0] memStoreData,
    output logic              wbValid,
    output logic [REG_AW-1:0] wbReg,
    output logic [WORD_W-1:0] wbData,
    output logic              halted
);

    logic [WORD_W-1:0]        dataMem [2**dataAddrWidth];
    logic [dataAddrWidth-1:0] addr;
    logic                     isStore;

    // Only the low address bits reach the memory
    assign addr    = memResult[dataAddrWidth-1:0];
    assign isStore = memValid && (memOp == OP_ST);

    always_ff @(posedge clk) begin
        if (isStore) begin
            dataMem[addr] <= memStoreData;
        end
    end

    // Loads return memory data, everything else passes its result
    always_ff @(posedge clk) begin
        wbReg <= memDest;
        if (memOp == OP_LD) begin
            wbData <= dataMem[addr];
        end else begin
            wbData <= memResult;
        end
    end

    // One strobe per retiring register writer
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            halted  <= 1'b0;
        end else begin
            wbValid <= memValid && memWrites;
            if (memValid && memOp == OP_HALT) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

//--- tb.f
+incdir+testbench
src/corePkg.sv
src/hazardDetect.sv
src/decodeStage.sv
src/executeStage.sv
src/resultStage.sv
src/pipeCore.sv
testbench/tbPipeCore.sv

//--- testbench/isaModel.svh
// Instruction-level reference model of the core
//   Program buffer and expected writeback list
//   One assembler helper per opcode
//   Interpreter that walks the program in order
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

logic [WORD_W-1:0] progWords [$];
logic [REG_AW-1:0] expReg [$];
logic [WORD_W-1:0] expData [$];

// R format: op rs rt rd func
function automatic logic [WORD_W-1:0] asmAlu(input aluFuncT fn, input int rd, input int rs,
                                              input int rt);
    return {OP_ALU, rs[2:0], rt[2:0], rd[2:0], fn};
endfunction

function automatic logic [WORD_W-1:0] asmAddi(input int rd, input int rs, input int imm);
    return {OP_ADDI, rs[2:0], rd[2:0], imm[4:0]};
endfunction

function automatic logic [WORD_W-1:0] asmLd(input int rd, input int rs, input int imm);
    return {OP_LD, rs[2:0], rd[2:0], imm[4:0]};
endfunction

// Data register sits where a load keeps its destination
function automatic logic [WORD_W-1:0] asmSt(input int rt, input int rs, input int imm);
    return {OP_ST, rs[2:0], rt[2:0], imm[4:0]};
endfunction

function automatic logic [WORD_W-1:0] asmLbi(input int rd, input int imm);
    return {OP_LBI, rd[2:0], imm[7:0]};
endfunction

function automatic logic [WORD_W-1:0] asmBeqz(input int rs, input int off);
    return {OP_BEQZ, rs[2:0], off[7:0]};
endfunction

function automatic logic [WORD_W-1:0] asmBnez(input int rs, input int off);
    return {OP_BNEZ, rs[2:0], off[7:0]};
endfunction

function automatic logic [WORD_W-1:0] asmJ(input int off);
    return {OP_J, off[10:0]};
endfunction

function automatic logic [WORD_W-1:0] asmNop();
    return NOP_INST;
endfunction

function automatic logic [WORD_W-1:0] asmHalt();
    return {OP_HALT, 11'b0};
endfunction

function automatic void expectWrite(input logic [REG_AW-1:0] rd, input logic [WORD_W-1:0] v);
    expReg.push_back(rd);
    expData.push_back(v);
endfunction

// Executes progWords from address zero until HALT
function automatic void runModel();
    logic [WORD_W-1:0] regs [2**REG_AW];
    logic [WORD_W-1:0] dmem [2**DATA_AW];
    logic [WORD_W-1:0] w;
    logic [WORD_W-1:0] v;
    logic [WORD_W-1:0] ea;
    logic [WORD_W-1:0] imm5;
    logic [WORD_W-1:0] imm8;
    logic [REG_AW-1:0] rs;
    logic [REG_AW-1:0] rt;
    int                pc;
    int                nextPc;
    int                steps;
    bit                done;
    expReg.delete();
    expData.delete();
    foreach (regs[i]) begin
        regs[i] = '0;
    end
    foreach (dmem[i]) begin
        dmem[i] = '0;
    end
    pc    = 0;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 4096) begin
        // Past the program end the instruction memory holds NOPs
        w      = (pc >= 0 && pc < progWords.size()) ? progWords[pc] : NOP_INST;
        rs     = w[10:8];
        rt     = w[7:5];
        imm5   = {{(WORD_W-5){w[4]}}, w[4:0]};
        imm8   = {{(WORD_W-8){w[7]}}, w[7:0]};
        ea     = regs[rs] + imm5;
        nextPc = pc + 1;
        case (opcodeT'(w[15:11]))
            OP_ALU: begin
                case (aluFuncT'(w[1:0]))
                    FN_ADD:  v = regs[rs] + regs[rt];
                    FN_SUB:  v = regs[rs] - regs[rt];
                    FN_AND:  v = regs[rs] & regs[rt];
                    FN_XOR:  v = regs[rs] ^ regs[rt];
                    default: v = '0;
                endcase
                regs[w[4:2]] = v;
                expectWrite(w[4:2], v);
            end
            OP_ADDI: begin
                regs[rt] = ea;
                expectWrite(rt, ea);
            end
            OP_LD: begin
                v        = dmem[ea[DATA_AW-1:0]];
                regs[rt] = v;
                expectWrite(rt, v);
            end
            OP_ST: dmem[ea[DATA_AW-1:0]] = regs[rt];
            // LBI loads its own rs field
            OP_LBI: begin
                regs[rs] = imm8;
                expectWrite(rs, imm8);
            end
            OP_BEQZ: begin
                if (regs[rs] == '0) begin
                    nextPc = pc + 1 + int'($signed(w[7:0]));
                end
            end
            OP_BNEZ: begin
                if (regs[rs] != '0) begin
                    nextPc = pc + 1 + int'($signed(w[7:0]));
                end
            end
            OP_J:    nextPc = pc + 1 + int'($signed(w[10:0]));
            OP_HALT: done = 1'b1;
            default: begin
                v = '0;
            end
        endcase
        pc = nextPc;
        steps++;
    end
endfunction

`endif

//--- testbench/tbPipeCore.sv
// Testbench for the pipelined integer core
//   Clock, synchronous reset and instruction memory on the fetch port
//   Directed tests checked against the instruction-level model
//   Watchdog sized from the program lengths
module tbPipeCore import corePkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_AW = 8;
    localparam int INST_AW = 8;

    logic              clk = 1'b0;
    logic              rstN = 1'b0;
    logic [WORD_W-1:0] inst;
    logic [WORD_W-1:0] pc;
    logic              stall;
    logic              wbValid;
    logic [REG_AW-1:0] wbReg;
    logic [WORD_W-1:0] wbData;
    logic              halted;

    logic [WORD_W-1:0] instMem [2**INST_AW];
    logic              stallSeen;
    int                cycleBudget = 0;
    int                cycleCount = 0;
    integer            seed = 32'ha52e;

    `include "isaModel.svh"

    pipeCore #(
        .dataAddrWidth (DATA_AW)
    ) u_dut (
        .clk     (clk),
        .rstN    (rstN),
        .inst    (inst),
        .pc      (pc),
        .stall   (stall),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData),
        .halted  (halted)
    );

    // Fetch answers in the same cycle, undefined pc before reset reads a NOP
    assign inst = $isunknown(pc) ? NOP_INST : instMem[pc[INST_AW-1:0]];

    initial begin
        forever #5 clk = ~clk;
    end

    // 40 cycles per program instruction, budget grows as tests load programs
    initial begin
        while (cycleCount <= cycleBudget) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout after %0d cycles, budget was %0d", cycleCount, cycleBudget);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    // Loads progWords, resets the core and checks every writeback in order
    task automatic runProgram(input string name);
        int wbIndex;
        runModel();
        cycleBudget += 40 * progWords.size();
        @(negedge clk);
        // Unused words are NOPs carrying their own address
        for (int a = 0; a < 2**INST_AW; a++) begin
            if (a < progWords.size()) begin
                instMem[a] = progWords[a];
            end else begin
                instMem[a] = {OP_NOP, 3'b000, a[INST_AW-1:0]};
            end
        end
        rstN = 1'b0;
        repeat (5) @(negedge clk);
        assert (pc == '0 && !wbValid && !halted && !stall) else
            stopOnError($sformatf(
                "error %s: after reset expected pc=0000 wb=0 halted=0 stall=0, actual %h %b %b %b",
                name, pc, wbValid, halted, stall));
        rstN      = 1'b1;
        stallSeen = 1'b0;
        wbIndex   = 0;
        while (!halted) begin
            @(negedge clk);
            // Stalls once HALT has issued are not counted
            if (stall && int'(pc) < progWords.size()) begin
                stallSeen = 1'b1;
            end
            if (wbValid) begin
                assert (expReg.size() > 0) else
                    stopOnError($sformatf("%s: writeback of r%0d with no expected entry left",
                                          name, wbReg));
                assert (wbReg == expReg[0] && wbData == expData[0]) else
                    stopOnError($sformatf(
                        "error %s: writeback %0d expected r%0d=%h, actual r%0d=%h",
                        name, wbIndex, expReg[0], expData[0], wbReg, wbData));
                void'(expReg.pop_front());
                void'(expData.pop_front());
                wbIndex++;
            end
        end
        assert (expReg.size() == 0) else
            stopOnError($sformatf("%s: halted with %0d expected writebacks missing",
                                  name, expReg.size()));
        // Nothing may retire once halted
        repeat (4) begin
            @(negedge clk);
            assert (!wbValid) else
                stopOnError($sformatf("%s: writeback of r%0d after halted", name, wbReg));
        end
    endtask

    task automatic checkHaltOnly();
        progWords.delete();
        progWords.push_back(asmHalt());
        runProgram("haltOnly");
    endtask

    // Each operand gets EX->EX and MEM->EX sources
    task automatic checkForwarding();
        progWords.delete();
        progWords.push_back(asmLbi(1, 5));
        progWords.push_back(asmLbi(2, -3));
        progWords.push_back(asmAlu(FN_ADD, 3, 1, 2));
        progWords.push_back(asmAlu(FN_SUB, 4, 3, 1));
        progWords.push_back(asmAlu(FN_XOR, 5, 4, 3));
        progWords.push_back(asmAddi(6, 5, 7));
        progWords.push_back(asmAlu(FN_AND, 7, 6, 5));
        progWords.push_back(asmAddi(1, 1, -1));
        progWords.push_back(asmAlu(FN_ADD, 2, 1, 1));
        progWords.push_back(asmAlu(FN_SUB, 3, 2, 1));
        progWords.push_back(asmHalt());
        runProgram("forwarding");
    endtask

    // Load-use on an ALU operand and on store data
    task automatic checkLoadStore();
        progWords.delete();
        progWords.push_back(asmLbi(1, 20));
        progWords.push_back(asmLbi(2, 90));
        progWords.push_back(asmSt(2, 1, 3));
        progWords.push_back(asmLd(3, 1, 3));
        progWords.push_back(asmAlu(FN_ADD, 4, 3, 2));
        progWords.push_back(asmLbi(5, -7));
        progWords.push_back(asmSt(5, 1, -2));
        progWords.push_back(asmLd(6, 1, -2));
        progWords.push_back(asmSt(6, 1, 4));
        progWords.push_back(asmLd(7, 1, 4));
        progWords.push_back(asmAlu(FN_XOR, 0, 7, 3));
        progWords.push_back(asmHalt());
        runProgram("loadStore");
        assert (stallSeen) else
            stopOnError("loadStore: stall never went high during the load-use sequence");
    endtask

    // Skipped slots would write r3, r4, r5 and r6 if they ran
    task automatic checkBranches();
        progWords.delete();
        progWords.push_back(asmLbi(1, 0));
        progWords.push_back(asmLbi(2, 3));
        progWords.push_back(asmBeqz(1, 1));
        progWords.push_back(asmLbi(3, 1));
        progWords.push_back(asmBnez(1, 1));
        progWords.push_back(asmAddi(3, 2, 1));
        progWords.push_back(asmBnez(3, 2));
        progWords.push_back(asmLbi(4, 2));
        progWords.push_back(asmLbi(5, 3));
        progWords.push_back(asmBeqz(2, 1));
        progWords.push_back(asmJ(1));
        progWords.push_back(asmLbi(6, 4));
        progWords.push_back(asmAlu(FN_ADD, 7, 3, 2));
        // Countdown loop, backward branch taken twice
        progWords.push_back(asmAddi(2, 2, -1));
        progWords.push_back(asmBnez(2, -2));
        progWords.push_back(asmHalt());
        runProgram("branches");
    endtask

    // Eight register inits, then 32 random ALU, ADDI and LBI instructions
    task automatic checkRandomProgram();
        int r;
        progWords.delete();
        for (int i = 0; i < 8; i++) begin
            r = $random(seed);
            progWords.push_back(asmLbi(i, r));
        end
        for (int i = 0; i < 32; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd2: progWords.push_back(asmAddi((r >> 2) & 7, (r >> 5) & 7, r >> 16));
                2'd3: progWords.push_back(asmLbi((r >> 2) & 7, r >> 16));
                default: begin
                    progWords.push_back(asmAlu(aluFuncT'(r[12:11]), (r >> 2) & 7,
                                               (r >> 5) & 7, (r >> 8) & 7));
                end
            endcase
        end
        progWords.push_back(asmHalt());
        runProgram("randomProgram");
    endtask

    initial begin
        checkHaltOnly();
        checkForwarding();
        checkLoadStore();
        checkBranches();
        checkRandomProgram();
        $display("Test completed successfully");
        $finish;
    end

endmodule
